// ==== verilog/idu_pkg.sv ====
`default_nettype none

package idu_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 4;
	localparam int reg_count  = 16;

	// opcode bits 6:2 of each class.
	localparam logic [4:0] op5_lui     = 5'b01101;
	localparam logic [4:0] op5_auipc   = 5'b00101;
	localparam logic [4:0] op5_jal     = 5'b11011;
	localparam logic [4:0] op5_jalr    = 5'b11001;
	localparam logic [4:0] op5_branch  = 5'b11000;
	localparam logic [4:0] op5_load    = 5'b00000;
	localparam logic [4:0] op5_store   = 5'b01000;
	localparam logic [4:0] op5_op_imm  = 5'b00100;
	localparam logic [4:0] op5_op      = 5'b01100;
	localparam logic [4:0] op5_system  = 5'b11100;
	localparam logic [4:0] op5_miscmem = 5'b00011;

	localparam logic [31:0] word_ecall = 32'h0000_0073;
	localparam logic [31:0] word_mret  = 32'h3020_0073;

	// bit positions in the one-hot class vector; last entry is its width.
	typedef enum int {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_op_imm,
		cls_op,
		cls_system,
		cls_count
	} op_class_e;

	typedef logic [cls_count-1:0] op_class_t;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} reg_view;
		struct packed {
			logic        sign;
			logic [10:0] hi;
			logic [7:0]  mid;
			logic [3:0]  lo;
			logic        b7;
			logic [6:0]  opcode;
		} imm_view;
	} inst_word_u;

	typedef struct packed {
		logic                  busy;
		logic                  load;
		logic                  reg_wen;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       value;
	} stage_status_t;

	typedef struct packed {
		op_class_t             op_class;
		logic [2:0]            funct3;
		logic                  funct7_5;
		logic [reg_addr_w-1:0] rd;
		logic                  reg_wen;
		logic                  fencei;
		logic                  ecall;
		logic                  mret;
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       dnpc;
		logic [xlen-1:0]       src1;
		logic [xlen-1:0]       src2;
		logic [xlen-1:0]       imm;
	} issue_bundle_t;

	typedef struct packed {
		op_class_t             op_class;
		logic [2:0]            funct3;
		logic                  funct7_5;
		logic [reg_addr_w-1:0] rd;
		logic                  reg_wen;
		logic                  fencei;
		logic                  ecall;
		logic                  mret;
		logic [xlen-1:0]       imm;
		logic                  need_rs1;
		logic                  need_rs2;
	} decode_t;

endpackage

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic [idu_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [idu_pkg::reg_addr_w-1:0] rs2_addr,
	output logic [idu_pkg::xlen-1:0]       rs1_data,
	output logic [idu_pkg::xlen-1:0]       rs2_data,
	input  logic                           wb_en,
	input  logic [idu_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [idu_pkg::xlen-1:0]       wb_val
);
	import idu_pkg::*;

	logic [xlen-1:0] regs [reg_count];

	// x0 is never written, so it stays at its reset value of zero.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_val;
		end
	end

	// no bypass from the write port.
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
	input  idu_pkg::inst_word_u inst,
	output idu_pkg::decode_t    dec
);
	import idu_pkg::*;

	logic [4:0]      op5;
	op_class_t       cls;
	logic            fmt_r;
	logic            fmt_i;
	logic            fmt_s;
	logic            fmt_b;
	logic            fmt_u;
	logic            fmt_j;
	logic [xlen-1:0] imm;

	assign op5 = inst.reg_view.opcode[6:2];

	assign cls[cls_lui]    = (op5 == op5_lui);
	assign cls[cls_auipc]  = (op5 == op5_auipc);
	assign cls[cls_jal]    = (op5 == op5_jal);
	assign cls[cls_jalr]   = (op5 == op5_jalr);
	assign cls[cls_branch] = (op5 == op5_branch);
	assign cls[cls_load]   = (op5 == op5_load);
	assign cls[cls_store]  = (op5 == op5_store);
	assign cls[cls_op_imm] = (op5 == op5_op_imm);
	assign cls[cls_op]     = (op5 == op5_op);
	assign cls[cls_system] = (op5 == op5_system);

	assign fmt_r = cls[cls_op];
	assign fmt_i = cls[cls_jalr] | cls[cls_load] | cls[cls_op_imm] | cls[cls_system];
	assign fmt_s = cls[cls_store];
	assign fmt_b = cls[cls_branch];
	assign fmt_u = cls[cls_lui] | cls[cls_auipc];
	assign fmt_j = cls[cls_jal];

	// immediate assembled slice by slice, sign bit is always inst[31].
	always_comb begin
		imm[31]    = inst.imm_view.sign;
		imm[30:20] = fmt_u ? inst.imm_view.hi : {11{inst.imm_view.sign}};
		imm[19:12] = (fmt_u | fmt_j) ? inst.imm_view.mid : {8{inst.imm_view.sign}};
		if (fmt_b)
			imm[11] = inst.imm_view.b7;
		else if (fmt_u)
			imm[11] = 1'b0;
		else if (fmt_j)
			imm[11] = inst.imm_view.hi[0];
		else
			imm[11] = inst.imm_view.sign;
		imm[10:5] = fmt_u ? 6'b0 : inst.imm_view.hi[10:5];
		if (fmt_i | fmt_j)
			imm[4:1] = inst.imm_view.hi[4:1];
		else if (fmt_u)
			imm[4:1] = 4'b0;
		else
			imm[4:1] = inst.imm_view.lo;
		if (fmt_i)
			imm[0] = inst.imm_view.hi[0];
		else if (fmt_s)
			imm[0] = inst.imm_view.b7;
		else
			imm[0] = 1'b0;
	end

	assign dec.op_class = cls;
	assign dec.funct3   = inst.reg_view.funct3;
	assign dec.funct7_5 = inst.reg_view.funct7[5];
	assign dec.rd       = inst.reg_view.rd[reg_addr_w-1:0];
	// ecall, ebreak and mret write no register.
	assign dec.reg_wen  = (fmt_i & ~(cls[cls_system] & inst.reg_view.funct3 == 3'b0))
		| fmt_r | fmt_u | fmt_j;
	assign dec.fencei   = (op5 == op5_miscmem);
	assign dec.ecall    = (inst == word_ecall);
	assign dec.mret     = (inst == word_mret);
	assign dec.imm      = imm;
	assign dec.need_rs2 = cls[cls_branch] | cls[cls_store] | cls[cls_op];
	assign dec.need_rs1 = dec.need_rs2 | cls[cls_jalr] | cls[cls_load]
		| cls[cls_op_imm] | cls[cls_system];

endmodule

`default_nettype wire

// ==== verilog/operand_forward.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_forward (
	input  logic [idu_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [idu_pkg::reg_addr_w-1:0] rs2_addr,
	input  logic [idu_pkg::xlen-1:0]       rs1_data,
	input  logic [idu_pkg::xlen-1:0]       rs2_data,
	input  logic                           need_rs1,
	input  logic                           need_rs2,
	input  idu_pkg::stage_status_t         exu_status,
	input  idu_pkg::stage_status_t         lsu_status,
	output logic [idu_pkg::xlen-1:0]       src1,
	output logic [idu_pkg::xlen-1:0]       src2,
	output logic                           stall
);
	import idu_pkg::*;

	logic rs1_exu_hit;
	logic rs2_exu_hit;
	logic rs1_lsu_hit;
	logic rs2_lsu_hit;

	// stage still owes a write to this source.
	function automatic logic hit(input stage_status_t st, input logic [reg_addr_w-1:0] addr,
		input logic need);
		return need & st.busy & st.reg_wen & (st.rd != '0) & (st.rd == addr);
	endfunction

	assign rs1_exu_hit = hit(exu_status, rs1_addr, need_rs1);
	assign rs2_exu_hit = hit(exu_status, rs2_addr, need_rs2);
	assign rs1_lsu_hit = hit(lsu_status, rs1_addr, need_rs1);
	assign rs2_lsu_hit = hit(lsu_status, rs2_addr, need_rs2);

	// execute is younger, so it wins.
	assign src1 = rs1_exu_hit ? exu_status.value :
		rs1_lsu_hit ? lsu_status.value : rs1_data;
	assign src2 = rs2_exu_hit ? exu_status.value :
		rs2_lsu_hit ? lsu_status.value : rs2_data;

	// load data is not ready yet.
	assign stall = (exu_status.load & (rs1_exu_hit | rs2_exu_hit))
		| (lsu_status.load & (rs1_lsu_hit | rs2_lsu_hit));

endmodule

`default_nettype wire

// ==== verilog/idu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module idu_control (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic                     stall,
	input  logic                     flush,
	output logic                     out_valid,
	input  logic                     out_ready,
	input  idu_pkg::decode_t         dec,
	input  logic [idu_pkg::xlen-1:0] pc,
	input  logic [idu_pkg::xlen-1:0] dnpc,
	input  logic [idu_pkg::xlen-1:0] src1,
	input  logic [idu_pkg::xlen-1:0] src2,
	output idu_pkg::issue_bundle_t   issue
);
	import idu_pkg::*;

	logic          ready_q;
	logic          valid_q;
	logic          accept;
	logic          send;
	issue_bundle_t issue_q;

	assign in_ready  = ready_q & ~stall;
	assign out_valid = valid_q;
	assign accept    = in_valid & in_ready;
	assign send      = valid_q & out_ready;

	// one slot; flush empties it regardless of the handshake.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b1;
			valid_q <= 1'b0;
		end else begin
			ready_q <= flush | (ready_q & ~accept) | (~ready_q & send);
			valid_q <= ~flush & ((valid_q & ~out_ready) | (~valid_q & accept));
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			issue_q <= '0;
		end else if (accept) begin
			issue_q.op_class <= dec.op_class;
			issue_q.funct3   <= dec.funct3;
			issue_q.funct7_5 <= dec.funct7_5;
			issue_q.rd       <= dec.rd;
			issue_q.reg_wen  <= dec.reg_wen;
			issue_q.fencei   <= dec.fencei;
			issue_q.ecall    <= dec.ecall;
			issue_q.mret     <= dec.mret;
			issue_q.pc       <= pc;
			issue_q.dnpc     <= dnpc;
			issue_q.src1     <= src1;
			issue_q.src2     <= src2;
			issue_q.imm      <= dec.imm;
		end
	end

	assign issue = issue_q;

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
	input  logic                           clock,
	input  logic                           rst_n,
	input  idu_pkg::inst_word_u            inst,
	input  logic [idu_pkg::xlen-1:0]       pc,
	input  logic [idu_pkg::xlen-1:0]       dnpc,
	input  logic                           in_valid,
	output logic                           in_ready,
	input  idu_pkg::stage_status_t         exu_status,
	input  idu_pkg::stage_status_t         lsu_status,
	input  logic                           wb_en,
	input  logic [idu_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [idu_pkg::xlen-1:0]       wb_val,
	input  logic                           flush,
	input  logic                           out_ready,
	output idu_pkg::issue_bundle_t         issue,
	output logic                           out_valid
);
	import idu_pkg::*;

	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic [xlen-1:0]       src1;
	logic [xlen-1:0]       src2;
	logic                  stall;
	decode_t               dec;

	// rv32e has sixteen registers, upper address bit is ignored.
	assign rs1_addr = inst.reg_view.rs1[reg_addr_w-1:0];
	assign rs2_addr = inst.reg_view.rs2[reg_addr_w-1:0];

	reg_file i_reg_file (
		.clock    (clock),
		.rst_n    (rst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_en    (wb_en),
		.wb_rd    (wb_rd),
		.wb_val   (wb_val)
	);

	inst_decoder i_inst_decoder (
		.inst (inst),
		.dec  (dec)
	);

	operand_forward i_operand_forward (
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.need_rs1   (dec.need_rs1),
		.need_rs2   (dec.need_rs2),
		.exu_status (exu_status),
		.lsu_status (lsu_status),
		.src1       (src1),
		.src2       (src2),
		.stall      (stall)
	);

	idu_control i_idu_control (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.stall     (stall),
		.flush     (flush),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.dec       (dec),
		.pc        (pc),
		.dnpc      (dnpc),
		.src1      (src1),
		.src2      (src2),
		.issue     (issue)
	);

endmodule

`default_nettype wire

// ==== test/decode_stage_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage_chk (
	input logic                   clock,
	input logic                   rst_n,
	input logic                   flush,
	input logic                   out_valid,
	input logic                   out_ready,
	input idu_pkg::issue_bundle_t issue
);

	// nothing valid straight out of reset.
	a_reset_idle: assert property (@(posedge clock) !rst_n |=> !out_valid)
		else $error("out_valid high after reset");

	a_hold_stable: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready && !flush |=> $stable(issue))
		else $error("issue changed while held");

	a_flush_drop: assert property (@(posedge clock) disable iff (!rst_n)
		flush |=> !out_valid)
		else $error("out_valid high after flush");

endmodule

bind idu_control decode_stage_chk i_decode_stage_chk (
	.clock     (clock),
	.rst_n     (rst_n),
	.flush     (flush),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.issue     (issue)
);

`default_nettype wire

// ==== test/decode_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb;
	import idu_pkg::*;

	localparam int rec_words = 13;

	logic            clock;
	logic            rst_n;
	inst_word_u      inst;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] dnpc;
	logic            in_valid;
	logic            in_ready;
	stage_status_t   exu_status;
	stage_status_t   lsu_status;
	logic            wb_en;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0] wb_val;
	logic            flush;
	logic            out_ready;
	issue_bundle_t   issue;
	logic            out_valid;

	logic [31:0] tdata [256];
	integer      seed;
	int          pass_count;
	int          fail_count;
	int          errors;

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	decode_stage i_decode_stage (
		.clock      (clock),
		.rst_n      (rst_n),
		.inst       (inst),
		.pc         (pc),
		.dnpc       (dnpc),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.exu_status (exu_status),
		.lsu_status (lsu_status),
		.wb_en      (wb_en),
		.wb_rd      (wb_rd),
		.wb_val     (wb_val),
		.flush      (flush),
		.out_ready  (out_ready),
		.issue      (issue),
		.out_valid  (out_valid)
	);

	task automatic check_bundle(input string name, input issue_bundle_t exp,
		input issue_bundle_t act);
		if (exp !== act) begin
			$display("** Error: %s issue expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input string sig, input logic exp,
		input logic act);
		if (exp !== act) begin
			$display("** Error: %s %s expected %b actual %b", name, sig, exp, act);
			errors++;
		end
	endtask

	function automatic stage_status_t to_status(input logic [31:0] ctl,
		input logic [31:0] val);
		stage_status_t st;
		st.busy    = ctl[6];
		st.load    = ctl[5];
		st.reg_wen = ctl[4];
		st.rd      = ctl[3:0];
		st.value   = val;
		return st;
	endfunction

	// one record: drive, wait for the handshakes, compare.
	task automatic run_test(input int base);
		string         name;
		int            mode;
		int            wait_cycles;
		logic [31:0]   ctl;
		issue_bundle_t exp;
		name = $sformatf("test %0d", tdata[base]);
		mode = tdata[base+1];
		ctl  = tdata[base+9];
		exp.op_class = ctl[21:12];
		exp.funct3   = ctl[11:9];
		exp.funct7_5 = ctl[8];
		exp.rd       = ctl[7:4];
		exp.reg_wen  = ctl[3];
		exp.fencei   = ctl[2];
		exp.ecall    = ctl[1];
		exp.mret     = ctl[0];
		exp.pc       = tdata[base+3];
		exp.dnpc     = tdata[base+4];
		exp.src1     = tdata[base+10];
		exp.src2     = tdata[base+11];
		exp.imm      = tdata[base+12];
		errors = 0;
		@(negedge clock);
		inst       = tdata[base+2];
		pc         = tdata[base+3];
		dnpc       = tdata[base+4];
		exu_status = to_status(tdata[base+5], tdata[base+6]);
		lsu_status = to_status(tdata[base+7], tdata[base+8]);
		in_valid   = 1'b1;
		out_ready  = 1'b0;
		flush      = (mode == 2);
		if (mode == 1) begin
			repeat (2) @(negedge clock);
			check_bit(name, "in_ready during stall", 1'b0, in_ready);
			check_bit(name, "out_valid during stall", 1'b0, out_valid);
			exu_status.busy = 1'b0;
			lsu_status.busy = 1'b0;
		end
		#1;
		while (!in_ready) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		in_valid = 1'b0;
		flush    = 1'b0;
		if (mode == 2) begin
			check_bit(name, "out_valid after flush", 1'b0, out_valid);
			check_bit(name, "in_ready after flush", 1'b1, in_ready);
			@(negedge clock);
			check_bit(name, "out_valid after flush", 1'b0, out_valid);
		end else begin
			check_bit(name, "out_valid after accept", 1'b1, out_valid);
			check_bundle(name, exp, issue);
			if (mode == 3) begin
				wait_cycles = 1 + int'($unsigned($random(seed)) % 6);
				// a second instruction waits behind the held one.
				pc       = dnpc;
				dnpc     = dnpc + 32'd4;
				in_valid = 1'b1;
				repeat (wait_cycles) begin
					@(negedge clock);
					check_bit(name, "in_ready while held", 1'b0, in_ready);
					check_bundle(name, exp, issue);
				end
				in_valid = 1'b0;
			end
			out_ready = 1'b1;
			@(negedge clock);
			out_ready = 1'b0;
			check_bit(name, "out_valid after transfer", 1'b0, out_valid);
			check_bit(name, "in_ready after transfer", 1'b1, in_ready);
		end
		exu_status = '0;
		lsu_status = '0;
		if (errors == 0) begin
			pass_count++;
			$display("%s passed", name);
		end else begin
			fail_count++;
			$display("%s failed with %0d errors", name, errors);
		end
	endtask

	initial begin
		seed       = 71135;
		pass_count = 0;
		fail_count = 0;
		rst_n      = 1'b0;
		inst       = '0;
		pc         = '0;
		dnpc       = '0;
		in_valid   = 1'b0;
		exu_status = '0;
		lsu_status = '0;
		wb_en      = 1'b0;
		wb_rd      = '0;
		wb_val     = '0;
		flush      = 1'b0;
		out_ready  = 1'b0;
		$readmemh("test/decode_testdata.txt", tdata);
		repeat (8) @(negedge clock);
		rst_n = 1'b1;
		for (int p = 0; p < int'(tdata[0]); p++) begin
			@(negedge clock);
			wb_en  = 1'b1;
			wb_rd  = tdata[2 + 2 * p][reg_addr_w-1:0];
			wb_val = tdata[3 + 2 * p];
		end
		@(negedge clock);
		wb_en = 1'b0;
		for (int t = 0; t < int'(tdata[1]); t++) begin
			run_test(2 + 2 * int'(tdata[0]) + t * rec_words);
		end
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// forty cycles per record plus reset and preload.
	initial begin
		longint limit;
		#1;
		limit = (longint'(tdata[1]) * 40 + longint'(tdata[0]) + 12) * 40;
		#(limit);
		$display("timeout: the tests did not finish in the expected time");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/decode_testdata.txt ====
// head: preload count, test count, then pairs of rd and value
// test: num mode inst pc dnpc exu_ctl exu_val lsu_ctl lsu_val exp_ctl exp_src1 exp_src2 exp_imm
// mode 0 plain 1 stall 2 flush 3 backpressure, status ctl {busy,load,reg_wen,rd}
// exp_ctl {op_class,funct3,funct7_5,rd,reg_wen,fencei,ecall,mret}
4 f
1 11111111
2 22222222
3 33333333
5 55555555
1 0 12345237 80000000 80000004 0 0 0 0 1a48 0 33333333 12345000
2 0 fffff317 80000004 80000008 0 0 0 0 2f68 0 0 fffff000
3 0 ffdff0ef 80000008 8000000c 0 0 0 0 4f18 0 0 fffffffc
4 0 00808167 8000000c 80000010 58 0000dead 0 0 8028 11111111 0 8
5 0 00208863 80000010 80000014 52 aaaa0002 52 bbbb0002 10000 11111111 aaaa0002 10
6 0 ffc1a383 80000014 80000018 0 0 53 30303030 20578 30303030 0 fffffffc
7 1 0051a623 80000018 8000001c 75 00000099 0 0 404c0 33333333 55555555 c
8 0 fff00493 8000001c 80000020 50 eeeeeeee 0 0 80198 0 0 ffffffff
9 3 40208533 80000020 80000024 0 0 0 0 1001a8 11111111 22222222 40a
a 0 00000073 80000024 80000028 0 0 0 0 200002 0 0 0
b 0 30200073 80000028 8000002c 0 0 0 0 200001 0 22222222 302
c 0 300295f3 8000002c 80000030 0 0 0 0 2002b8 55555555 0 300
d 0 0000100f 80000030 80000034 0 0 0 0 204 0 0 0
e 2 00208633 80000034 80000038 0 0 0 0 1000c8 11111111 22222222 c
f 3 7ff28693 80000038 8000003c 0 0 7d 0000000d 801d8 55555555 0 7ff

// ==== build.f ====
verilog/idu_pkg.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/operand_forward.sv
verilog/idu_control.sv
verilog/decode_stage.sv
test/decode_stage_chk.sv
test/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module decode_stage_tb -f build.f \
	-o decode_stage_sim \
	&& ./obj_dir/decode_stage_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^TB PASSED$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
